//--- hw/ps2_pkg.sv
package ps2_pkg;

    // One byte as sent on the PS/2 data line, LSB first
    typedef logic [7:0] scan_code_t;

    // Start bit, eight data bits and the parity bit, in arrival order
    typedef logic [9:0] frame_bits_t;

    localparam int FRAME_LEN = 11;      // Start, 8 data, parity, stop

    localparam int SYNC_STAGES = 3;     // Flops on ps2_clk, data uses one less

endpackage

//--- hw/key_pkg.sv
package key_pkg;

    typedef logic [7:0] ascii_t;        // Zero when the code has no character

    localparam int FIFO_DEPTH = 8;      // Must stay a power of two

    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;

    // Occupancy count, one bit wider than the pointers so full fits
    typedef logic [$clog2(FIFO_DEPTH):0] fifo_cnt_t;

    // Set-2 prefix bytes
    localparam ps2_pkg::scan_code_t BREAK_PREFIX = 8'hF0;
    localparam ps2_pkg::scan_code_t EXT_PREFIX   = 8'hE0;

endpackage

//--- hw/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                code_valid,
    output ps2_pkg::scan_code_t code,
    output logic                frame_error
);

    logic [ps2_pkg::SYNC_STAGES-1:0] clk_sync;    // Oldest sample in the top bit
    logic [ps2_pkg::SYNC_STAGES-2:0] data_sync;
    logic                            fall;
    logic                            data_bit;
    logic                            last_bit;
    logic                            frame_ok;
    logic [3:0]                      bit_cnt;     // Bits seen in the current frame
    ps2_pkg::frame_bits_t            frame;

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= '1;                      // Idle bus is high
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[ps2_pkg::SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[ps2_pkg::SYNC_STAGES-3:0], ps2_data};
        end
    end

    assign fall     = clk_sync[ps2_pkg::SYNC_STAGES-1] & ~clk_sync[ps2_pkg::SYNC_STAGES-2];
    assign data_bit = data_sync[ps2_pkg::SYNC_STAGES-2];
    assign last_bit = (bit_cnt == 4'(ps2_pkg::FRAME_LEN - 1));  // Stop bit on the line

    // Start low, stop high, data plus parity odd
    assign frame_ok = ~frame[0] & data_bit & (^frame[$bits(frame)-1:1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid  <= 1'b0;                  // Strobes last one cycle
            frame_error <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt     <= '0;            // Next frame starts fresh
                    code_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            if (last_bit) begin
                code <= frame[8:1];               // Data byte sits between start and parity
            end else begin
                frame <= {data_bit, frame[$bits(frame)-1:1]};  // LSB first, shift right
            end
        end
    end

endmodule

//--- hw/scan_fifo.sv
`timescale 1ns/1ps

module scan_fifo (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  ps2_pkg::scan_code_t push_code,
    input  logic                fifo_ready,
    output logic                fifo_valid,
    output ps2_pkg::scan_code_t fifo_code,
    output logic                overflow
);

    ps2_pkg::scan_code_t mem [key_pkg::FIFO_DEPTH];
    key_pkg::fifo_ptr_t  wr_ptr;
    key_pkg::fifo_ptr_t  rd_ptr;
    key_pkg::fifo_cnt_t  count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    assign full       = (count == key_pkg::fifo_cnt_t'(key_pkg::FIFO_DEPTH));
    assign fifo_valid = (count != '0);
    assign fifo_code  = mem[rd_ptr];              // Head entry, stable until popped

    assign do_push = push & ~full;                // Keyboard cannot wait, so drop
    assign do_pop  = fifo_valid & fifo_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;          // Wraps at the depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
            if (push && full) begin
                overflow <= 1'b1;                 // Held until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

endmodule

//--- hw/scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                fifo_valid,
    input  ps2_pkg::scan_code_t fifo_code,
    input  logic                key_ready,
    output logic                fifo_ready,
    output logic                key_valid,
    output ps2_pkg::scan_code_t key_code,
    output key_pkg::ascii_t     key_ascii,
    output logic                key_release,
    output logic                key_extended
);

    typedef enum logic [1:0] {
        ST_IDLE,                                  // No prefix pending
        ST_PREFIX,                                // F0 and/or E0 seen
        ST_HOLD                                   // Event waiting for key_ready
    } dec_state_t;

    dec_state_t state;
    logic       pend_break;
    logic       pend_ext;
    logic       take;
    logic       is_break;
    logic       is_ext;

    // Set-2 make codes for letters and digits
    function automatic key_pkg::ascii_t ascii_of(input ps2_pkg::scan_code_t sc);
        key_pkg::ascii_t a;
        case (sc)
            8'h1C:   a = 8'h41;                   // A
            8'h32:   a = 8'h42;
            8'h21:   a = 8'h43;
            8'h23:   a = 8'h44;
            8'h24:   a = 8'h45;
            8'h2B:   a = 8'h46;
            8'h34:   a = 8'h47;
            8'h33:   a = 8'h48;
            8'h43:   a = 8'h49;
            8'h3B:   a = 8'h4A;
            8'h42:   a = 8'h4B;
            8'h4B:   a = 8'h4C;
            8'h3A:   a = 8'h4D;
            8'h31:   a = 8'h4E;
            8'h44:   a = 8'h4F;
            8'h4D:   a = 8'h50;
            8'h15:   a = 8'h51;
            8'h2D:   a = 8'h52;
            8'h1B:   a = 8'h53;
            8'h2C:   a = 8'h54;
            8'h3C:   a = 8'h55;
            8'h2A:   a = 8'h56;
            8'h1D:   a = 8'h57;
            8'h22:   a = 8'h58;
            8'h35:   a = 8'h59;
            8'h1A:   a = 8'h5A;                   // Z
            8'h45:   a = 8'h30;                   // 0
            8'h16:   a = 8'h31;
            8'h1E:   a = 8'h32;
            8'h26:   a = 8'h33;
            8'h25:   a = 8'h34;
            8'h2E:   a = 8'h35;
            8'h36:   a = 8'h36;
            8'h3D:   a = 8'h37;
            8'h3E:   a = 8'h38;
            8'h46:   a = 8'h39;                   // 9
            default: a = 8'h00;
        endcase
        return a;
    endfunction

    assign fifo_ready = (state != ST_HOLD);       // Stalls while an event waits
    assign key_valid  = (state == ST_HOLD);
    assign take       = fifo_valid & fifo_ready;
    assign is_break   = (fifo_code == key_pkg::BREAK_PREFIX);
    assign is_ext     = (fifo_code == key_pkg::EXT_PREFIX);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            pend_break <= 1'b0;
            pend_ext   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_PREFIX: begin
                    if (take) begin
                        if (is_break) begin
                            pend_break <= 1'b1;
                            state      <= ST_PREFIX;
                        end else if (is_ext) begin
                            pend_ext <= 1'b1;
                            state    <= ST_PREFIX;
                        end else begin
                            pend_break <= 1'b0;   // Flags now live in the event
                            pend_ext   <= 1'b0;
                            state      <= ST_HOLD;
                        end
                    end
                end
                ST_HOLD: begin
                    if (key_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take && !is_break && !is_ext) begin
            key_code     <= fifo_code;
            key_ascii    <= pend_ext ? '0 : ascii_of(fifo_code);  // No text for E0 keys
            key_release  <= pend_break;
            key_extended <= pend_ext;
        end
    end

endmodule

//--- hw/ps2_keyboard_top.sv
`timescale 1ns/1ps

module ps2_keyboard_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                key_ready,
    output logic                key_valid,
    output ps2_pkg::scan_code_t key_code,
    output key_pkg::ascii_t     key_ascii,
    output logic                key_release,
    output logic                key_extended,
    output logic                overflow,
    output logic                frame_error
);

    logic                rx_valid;
    ps2_pkg::scan_code_t rx_code;
    logic                rx_error;                // One-cycle bad frame strobe
    logic                fifo_valid;
    logic                fifo_ready;
    ps2_pkg::scan_code_t fifo_code;

    ps2_frame_rx u_rx (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code_valid  (rx_valid),
        .code        (rx_code),
        .frame_error (rx_error)
    );

    scan_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (rx_valid),
        .push_code  (rx_code),
        .fifo_ready (fifo_ready),
        .fifo_valid (fifo_valid),
        .fifo_code  (fifo_code),
        .overflow   (overflow)
    );

    scan_decoder u_dec (
        .clk          (clk),
        .reset        (reset),
        .fifo_valid   (fifo_valid),
        .fifo_code    (fifo_code),
        .key_ready    (key_ready),
        .fifo_ready   (fifo_ready),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_ascii    (key_ascii),
        .key_release  (key_release),
        .key_extended (key_extended)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_error <= 1'b0;
        end else if (rx_error) begin
            frame_error <= 1'b1;                  // Sticky until reset
        end
    end

endmodule

//--- verif/tb_ps2_keyboard.sv
`timescale 1ns/1ps

module tb_ps2_keyboard;

    typedef enum int {
        READY_RANDOM,                             // About half the cycles
        READY_SPARSE,                             // About a quarter of the cycles
        READY_LOW                                 // Consumer stalled
    } ready_mode_t;

    logic                clk = 1'b0;
    logic                reset;
    logic                ps2_clk;
    logic                ps2_data;
    logic                key_ready;
    logic                key_valid;
    ps2_pkg::scan_code_t key_code;
    key_pkg::ascii_t     key_ascii;
    logic                key_release;
    logic                key_extended;
    logic                overflow;
    logic                frame_error;

    // Letters A to Z, digits 0 to 9, then codes with no character
    ps2_pkg::scan_code_t key_table [42] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
        8'h29, 8'h5A, 8'h66, 8'h76, 8'h0D, 8'h05
    };

    logic [17:0] exp_q [$];                       // {extended, release, ascii, code}
    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    ready_mode_t ready_mode;
    int          value_errors;
    int          other_errors;
    int          events_seen;
    int          dut_bytes;                       // Events held in FIFO and decoder
    logic        exp_overflow;
    logic        exp_frame_error;

    ps2_keyboard_top DUT (
        .clk          (clk),
        .reset        (reset),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_ready    (key_ready),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_ascii    (key_ascii),
        .key_release  (key_release),
        .key_extended (key_extended),
        .overflow     (overflow),
        .frame_error  (frame_error)
    );

    always #20 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    function automatic key_pkg::ascii_t expected_ascii(input int idx, input logic ext);
        key_pkg::ascii_t a;
        if (ext || idx >= 36) begin
            a = 8'h00;
        end else if (idx < 26) begin
            a = 8'h41 + 8'(idx);                  // Letters in alphabet order
        end else begin
            a = 8'h30 + 8'(idx - 26);
        end
        return a;
    endfunction

    task automatic check_code(input string what, input ps2_pkg::scan_code_t got,
                              input ps2_pkg::scan_code_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ascii(input string what, input key_pkg::ascii_t got,
                               input key_pkg::ascii_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Fault 1 flips parity and fault 2 sends a low stop bit
    task automatic send_frame(input ps2_pkg::scan_code_t data, input int fault);
        ps2_pkg::frame_bits_t bits;
        logic                 stop;
        bits = {~^data, data, 1'b0};              // Odd parity over data and parity
        stop = 1'b1;
        if (fault == 1) begin
            bits[9] = ~bits[9];
        end
        if (fault == 2) begin
            stop = 1'b0;
        end
        for (int i = 0; i < ps2_pkg::FRAME_LEN; i++) begin
            ps2_data = (i < ps2_pkg::FRAME_LEN - 1) ? bits[i] : stop;
            repeat (4) @(negedge clk);            // Data settles while ps2_clk high
            ps2_clk = 1'b0;
            repeat (8) @(negedge clk);
            ps2_clk = 1'b1;
            repeat (4) @(negedge clk);
        end
        ps2_data = 1'b1;
        repeat (16) @(negedge clk);               // Idle gap between frames
    endtask

    task automatic send_key(input int idx, input logic brk, input logic ext);
        ps2_pkg::scan_code_t code;
        key_pkg::ascii_t     ascii;
        code  = key_table[idx];
        ascii = expected_ascii(idx, ext);
        if (ext) begin
            send_frame(key_pkg::EXT_PREFIX, 0);
        end
        if (brk) begin
            send_frame(key_pkg::BREAK_PREFIX, 0);
        end
        if (dut_bytes < key_pkg::FIFO_DEPTH + 1) begin
            exp_q.push_back({ext, brk, ascii, code});
            dut_bytes++;
        end else begin
            exp_overflow = 1'b1;                  // No room so the byte is lost
        end
        send_frame(code, 0);
    endtask

    task automatic send_bad_frame(input int fault);
        logic [31:0] v;
        take_bits(8, v);
        send_frame(v[7:0], fault);
        exp_frame_error = 1'b1;
        check_flag("frame_error", frame_error, exp_frame_error);
    endtask

    task automatic random_key(input logic allow_prefix, input logic allow_bad);
        logic [31:0] v;
        int          idx;
        logic        brk;
        logic        ext;
        take_bits(6, v);
        idx = int'(v % 42);
        brk = 1'b0;
        ext = 1'b0;
        if (allow_prefix) begin
            take_bits(1, v);
            brk = v[0];
            take_bits(1, v);
            ext = v[0];
        end
        if (allow_bad) begin
            take_bits(2, v);
            if (v[1]) begin
                send_bad_frame(v[0] ? 2 : 1);
            end
        end
        send_key(idx, brk, ext);
    endtask

    // Restarts the count whenever an event is taken
    task automatic wait_drain();
        int idle;
        int seen;
        idle = 0;
        seen = events_seen;
        while (exp_q.size() != 0 && idle < 2000) begin
            @(negedge clk);
            if (events_seen != seen) begin
                seen = events_seen;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Timeout at %0t ns: no key event arrived, %0d events missing",
                     $time, exp_q.size());
            exp_q.delete();
            dut_bytes = 0;
        end
        repeat (40) @(negedge clk);               // Room for any stray event
    endtask

    always @(negedge clk) begin : consumer
        logic [17:0] exp;
        logic        take;
        ready_lfsr = lfsr_step(ready_lfsr);
        take = ready_lfsr[0];
        if (ready_mode == READY_SPARSE) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            take = take & ready_lfsr[0];
        end
        if (ready_mode == READY_LOW) begin
            take = 1'b0;
        end
        key_ready = take;
        if (key_valid === 1'b1 && take) begin     // Transfer on the next rising edge
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Unexpected key event with code %h at %0t ns", key_code, $time);
            end else begin
                exp = exp_q.pop_front();
                check_code("key_code", key_code, exp[7:0]);
                check_ascii("key_ascii", key_ascii, exp[15:8]);
                check_flag("key_release", key_release, exp[16]);
                check_flag("key_extended", key_extended, exp[17]);
                dut_bytes--;
                events_seen++;
            end
        end
    end

    initial begin
        reset           = 1'b1;
        ps2_clk         = 1'b1;
        ps2_data        = 1'b1;
        key_ready       = 1'b0;
        stim_lfsr       = 32'h3dd1;
        ready_lfsr      = 32'h3dd1;
        ready_mode      = READY_RANDOM;
        value_errors    = 0;
        other_errors    = 0;
        events_seen     = 0;
        dut_bytes       = 0;
        exp_overflow    = 1'b0;
        exp_frame_error = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("key_valid after reset", key_valid, 1'b0);
        check_flag("overflow after reset", overflow, 1'b0);
        check_flag("frame_error after reset", frame_error, 1'b0);

        // Every table entry as a plain make code
        for (int i = 0; i < 42; i++) begin
            send_key(i, 1'b0, 1'b0);
        end
        wait_drain();

        for (int i = 0; i < 24; i++) begin        // Break and extended prefixes
            random_key(1'b1, 1'b0);
        end
        wait_drain();
        check_flag("frame_error", frame_error, exp_frame_error);  // Only good frames so far

        send_bad_frame(1);
        send_bad_frame(2);
        for (int i = 0; i < 12; i++) begin
            random_key(1'b1, 1'b1);
        end
        wait_drain();

        ready_mode = READY_SPARSE;                // Heavy back-pressure
        for (int i = 0; i < 20; i++) begin
            random_key(1'b1, 1'b0);
        end
        wait_drain();
        check_flag("overflow", overflow, exp_overflow);

        // Stalled consumer lets the FIFO and the held event fill up
        ready_mode = READY_LOW;
        for (int i = 0; i < 12; i++) begin
            random_key(1'b0, 1'b0);
        end
        check_flag("overflow", overflow, exp_overflow);
        ready_mode = READY_RANDOM;
        wait_drain();
        check_flag("overflow", overflow, exp_overflow);
        check_flag("frame_error", frame_error, exp_frame_error);

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- project.f
hw/ps2_pkg.sv
hw/key_pkg.sv
hw/ps2_frame_rx.sv
hw/scan_fifo.sv
hw/scan_decoder.sv
hw/ps2_keyboard_top.sv
verif/tb_ps2_keyboard.sv

//--- Makefile
TOP  := tb_ps2_keyboard
SRCS := $(filter %.sv,$(shell cat project.f))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -o V$(TOP)

sim.log: $(BIN)
	./$(BIN) | tee sim.log

run: sim.log
	@grep -qx "Finished with no errors" sim.log || (echo "Simulation failed"; rm -f sim.log; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
